// ==== all.f ====
ac_pkg.sv
ac_cmd_encoder.sv
ac_pad.sv
ac_top.sv
ac_asserts.sv
tb_ac_top.sv

// ==== tb_ac_top.sv ====
// Address/command path testbench
`timescale 1ns/1ps

module tb_ac_top;

    import ac_pkg::*;

    // ******************************
    // Configuration
    // ******************************

    localparam int ADDR_WIDTH  = ADDR_WIDTH_DEF;
    localparam int BANK_WIDTH  = BANK_WIDTH_DEF;
    localparam int CS_WIDTH    = CS_WIDTH_DEF;
    localparam int CS_IDX_W    = $clog2(CS_WIDTH);
    localparam int WORD_WIDTH  = 4 + CS_WIDTH + BANK_WIDTH + ADDR_WIDTH;
    localparam int CKE_POS     = ADDR_WIDTH + BANK_WIDTH;

    // Latency from the driving edge to the memory pins with the boundary register on
    localparam int PIPE_DEPTH   = 3;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 4;
    localparam int DIRECTED     = 1 + 6 * CS_WIDTH + 2;
    localparam int NUM_RANDOM   = 400;

    // Stimulus length plus generous headroom, 600 cycles in all
    localparam int STIM_CYCLES = RESET_CYCLES + IDLE_CYCLES + DIRECTED + NUM_RANDOM + PIPE_DEPTH;
    localparam int CYCLE_LIMIT = STIM_CYCLES + 173;

    logic                  pll_afi_clk = 1'b0;
    logic                  rst;
    ac_cmd_t               afi_cmd;
    logic [CS_IDX_W-1:0]   afi_cs;
    logic [BANK_WIDTH-1:0] afi_ba;
    logic [ADDR_WIDTH-1:0] afi_addr;
    logic [CS_WIDTH-1:0]   mem_cs_n;
    logic                  mem_ras_n;
    logic                  mem_cas_n;
    logic                  mem_we_n;
    logic                  mem_cke;
    logic [BANK_WIDTH-1:0] mem_ba;
    logic [ADDR_WIDTH-1:0] mem_a;

    // Expected pin words in flight, oldest first
    logic [WORD_WIDTH-1:0] exp_q[$];
    logic [WORD_WIDTH-1:0] exp_word;
    logic                  model_cke;
    integer                seed;
    int                    push_cnt  = 0;
    int                    check_cnt = 0;
    int                    cycle_cnt = 0;

    ac_top i_ac_top (
        .pll_afi_clk (pll_afi_clk),
        .rst         (rst),
        .afi_cmd     (afi_cmd),
        .afi_cs      (afi_cs),
        .afi_ba      (afi_ba),
        .afi_addr    (afi_addr),
        .mem_cs_n    (mem_cs_n),
        .mem_ras_n   (mem_ras_n),
        .mem_cas_n   (mem_cas_n),
        .mem_we_n    (mem_we_n),
        .mem_cke     (mem_cke),
        .mem_ba      (mem_ba),
        .mem_a       (mem_a)
    );

    always #10 pll_afi_clk = ~pll_afi_clk;

    // ******************************
    // Reference model
    // ******************************

    // Pin word in the order cs_n, ras_n, cas_n, we_n, cke, ba, addr
    function automatic logic [WORD_WIDTH-1:0] expected_pins(
        input ac_cmd_t               cmd,
        input logic [CS_IDX_W-1:0]   cs,
        input logic [BANK_WIDTH-1:0] ba,
        input logic [ADDR_WIDTH-1:0] addr,
        input logic                  cke
    );
        logic [CS_WIDTH-1:0]   cs_n;
        logic [2:0]            strobes;
        logic                  cke_out;
        logic [BANK_WIDTH-1:0] ba_out;
        logic [ADDR_WIDTH-1:0] a_out;
        cs_n    = '1;
        cke_out = cke;
        ba_out  = ba;
        a_out   = addr;
        // Strobes as {ras_n, cas_n, we_n}
        case (cmd)
            CMD_ACT: strobes = 3'b011;
            CMD_RD:  strobes = 3'b101;
            CMD_WR:  strobes = 3'b100;
            CMD_PRE: strobes = 3'b010;
            CMD_REF: strobes = 3'b001;
            CMD_MRS: strobes = 3'b000;
            default: strobes = 3'b111;
        endcase
        if (cmd == CMD_NOP || cmd == CMD_PD) begin
            ba_out = '0;
            a_out  = '0;
            if (cmd == CMD_PD) begin
                cke_out = ~cke;
            end
        end else begin
            cs_n[cs] = 1'b0;
        end
        return {cs_n, strobes, cke_out, ba_out, a_out};
    endfunction

    // ******************************
    // Stimulus tasks
    // ******************************

    task automatic apply_reset(input int cycles);
        repeat (cycles) begin
            @(posedge pll_afi_clk);
            rst     <= 1'b1;
            afi_cmd <= CMD_NOP;
            model_cke = 1'b0;
            exp_q.push_back(expected_pins(CMD_NOP, '0, '0, '0, 1'b0));
            push_cnt++;
        end
    endtask

    task automatic drive_cmd(
        input ac_cmd_t               cmd,
        input logic [CS_IDX_W-1:0]   cs,
        input logic [BANK_WIDTH-1:0] ba,
        input logic [ADDR_WIDTH-1:0] addr
    );
        @(posedge pll_afi_clk);
        rst      <= 1'b0;
        afi_cmd  <= cmd;
        afi_cs   <= cs;
        afi_ba   <= ba;
        afi_addr <= addr;
        exp_q.push_back(expected_pins(cmd, cs, ba, addr, model_cke));
        push_cnt++;
        if (cmd == CMD_PD) begin
            model_cke = ~model_cke;
        end
    endtask

    // Random opcode, rank, bank and address on every cycle
    task automatic run_random(input int count);
        logic [31:0] r_cmd;
        logic [31:0] r_cs;
        logic [31:0] r_ba;
        logic [31:0] r_addr;
        for (int i = 0; i < count; i++) begin
            r_cmd  = $random(seed);
            r_cs   = $random(seed);
            r_ba   = $random(seed);
            r_addr = $random(seed);
            drive_cmd(ac_cmd_t'(r_cmd[2:0]), r_cs[CS_IDX_W-1:0],
                      r_ba[BANK_WIDTH-1:0], r_addr[ADDR_WIDTH-1:0]);
        end
    endtask

    task automatic compare_pin(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ******************************
    // Comparator
    // ******************************

    // Pins settle after the rising edge, so they are sampled on the falling one
    always @(negedge pll_afi_clk) begin
        assert (i_ac_top.i_ac_asserts.fail_cnt == 0) else begin
            $display("ERROR: a bound assertion on the memory pins failed at %0t ns", $time);
            $display("Simulation FAILED");
            $fatal(1, "Pin assertion failure");
        end
        if (exp_q.size() > PIPE_DEPTH) begin
            exp_word = exp_q.pop_front();
            compare_pin("mem_cs_n", exp_word[WORD_WIDTH-1 -: CS_WIDTH], mem_cs_n);
            compare_pin("mem_ras_n", exp_word[CKE_POS+3], mem_ras_n);
            compare_pin("mem_cas_n", exp_word[CKE_POS+2], mem_cas_n);
            compare_pin("mem_we_n", exp_word[CKE_POS+1], mem_we_n);
            compare_pin("mem_cke", exp_word[CKE_POS], mem_cke);
            compare_pin("mem_ba", exp_word[ADDR_WIDTH +: BANK_WIDTH], mem_ba);
            compare_pin("mem_a", exp_word[ADDR_WIDTH-1:0], mem_a);
            check_cnt++;
        end
    end

    // Run limit
    always @(posedge pll_afi_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "Timeout");
        end
    end

    // ******************************
    // Test sequence
    // ******************************

    initial begin
        rst       = 1'b1;
        afi_cmd   = CMD_NOP;
        afi_cs    = '0;
        afi_ba    = '0;
        afi_addr  = '0;
        model_cke = 1'b0;
        seed      = 32'h52d9;

        apply_reset(RESET_CYCLES);

        // Idle after reset, pins stay deselected with cke low
        repeat (IDLE_CYCLES) begin
            drive_cmd(CMD_NOP, '0, '0, '0);
        end

        // Power-up exit, then every command on each rank back to back
        drive_cmd(CMD_PD, '0, '0, '0);
        for (int cs = 0; cs < CS_WIDTH; cs++) begin
            drive_cmd(CMD_MRS, CS_IDX_W'(cs), 3'd2, 14'h0431);
            drive_cmd(CMD_ACT, CS_IDX_W'(cs), 3'd5, 14'h2a5c);
            drive_cmd(CMD_WR, CS_IDX_W'(cs), 3'd5, 14'h0408);
            drive_cmd(CMD_RD, CS_IDX_W'(cs), 3'd5, 14'h0010);
            drive_cmd(CMD_PRE, CS_IDX_W'(cs), 3'd5, 14'h0400);
            drive_cmd(CMD_REF, CS_IDX_W'(cs), 3'd7, 14'h3fff);
        end

        // Power-down entry and exit, cke high to low to high
        drive_cmd(CMD_PD, 1'b1, 3'd3, 14'h1234);
        drive_cmd(CMD_PD, 1'b0, 3'd6, 14'h0abc);

        run_random(NUM_RANDOM);

        // Flush the pipeline so the last command reaches the pins
        repeat (PIPE_DEPTH) begin
            drive_cmd(CMD_NOP, '0, '0, '0);
        end
        @(negedge pll_afi_clk);
        #1;

        if (check_cnt == push_cnt - PIPE_DEPTH) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("ERROR: compared %0d pin words but %0d were expected",
                     check_cnt, push_cnt - PIPE_DEPTH);
            $display("Simulation FAILED");
            $fatal(1, "Comparison count mismatch");
        end
    end

endmodule

// ==== ac_asserts.sv ====
// Memory pin assertions
`timescale 1ns/1ps

module ac_asserts #(
    parameter int CS_WIDTH = ac_pkg::CS_WIDTH_DEF
) (
    input logic                pll_afi_clk,
    input logic                rst,
    input logic [CS_WIDTH-1:0] mem_cs_n,
    input logic                mem_ras_n,
    input logic                mem_cas_n,
    input logic                mem_we_n,
    input logic                mem_cke
);

    // Number of failed assertions, watched by the testbench
    int fail_cnt = 0;

    // ******************************
    // Command pin rules
    // ******************************

    // With every rank deselected the strobes must idle high
    a_strobes_idle: assert property (@(posedge pll_afi_clk) disable iff (rst)
        (mem_cs_n == '1) |-> (mem_ras_n && mem_cas_n && mem_we_n))
    else begin
        $error("Strobe low while every chip select is high");
        fail_cnt++;
    end

    // A command addresses one rank at most
    a_one_rank: assert property (@(posedge pll_afi_clk) disable iff (rst)
        $onehot0(~mem_cs_n))
    else begin
        $error("More than one chip select driven low");
        fail_cnt++;
    end

    // cke only moves on a power-down toggle, which deselects all ranks
    a_cke_stable: assert property (@(posedge pll_afi_clk) disable iff (rst)
        (mem_cs_n != '1) |-> $stable(mem_cke))
    else begin
        $error("cke changed while a chip select was low");
        fail_cnt++;
    end

endmodule

bind ac_top ac_asserts #(
    .CS_WIDTH (CS_WIDTH)
) i_ac_asserts (
    .pll_afi_clk (pll_afi_clk),
    .rst         (rst),
    .mem_cs_n    (mem_cs_n),
    .mem_ras_n   (mem_ras_n),
    .mem_cas_n   (mem_cas_n),
    .mem_we_n    (mem_we_n),
    .mem_cke     (mem_cke)
);

// ==== ac_top.sv ====
// Address/command path top level
`timescale 1ns/1ps

module ac_top #(
    parameter int ADDR_WIDTH   = ac_pkg::ADDR_WIDTH_DEF,
    parameter int BANK_WIDTH   = ac_pkg::BANK_WIDTH_DEF,
    parameter int CS_WIDTH     = ac_pkg::CS_WIDTH_DEF,
    parameter bit REGISTER_C2P = 1'b1
) (
    input  logic                        pll_afi_clk,
    input  logic                        rst,
    input  ac_pkg::ac_cmd_t             afi_cmd,
    input  logic [$clog2(CS_WIDTH)-1:0] afi_cs,
    input  logic [BANK_WIDTH-1:0]       afi_ba,
    input  logic [ADDR_WIDTH-1:0]       afi_addr,
    output logic [CS_WIDTH-1:0]         mem_cs_n,
    output logic                        mem_ras_n,
    output logic                        mem_cas_n,
    output logic                        mem_we_n,
    output logic                        mem_cke,
    output logic [BANK_WIDTH-1:0]       mem_ba,
    output logic [ADDR_WIDTH-1:0]       mem_a
);

    // ******************************
    // Word layout
    // ******************************

    localparam int WORD_WIDTH = 4 + CS_WIDTH + BANK_WIDTH + ADDR_WIDTH;

    // Bit positions of the single-bit fields above the bank field
    localparam int CKE_BIT   = ADDR_WIDTH + BANK_WIDTH;
    localparam int WE_N_BIT  = CKE_BIT + 1;
    localparam int CAS_N_BIT = CKE_BIT + 2;
    localparam int RAS_N_BIT = CKE_BIT + 3;

    // Encoded word into the pad and registered word out of it
    logic [WORD_WIDTH-1:0] ac_afi_word;
    logic [WORD_WIDTH-1:0] ac_mem_word;

    // ******************************
    // Encoder and pad
    // ******************************

    ac_cmd_encoder #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BANK_WIDTH (BANK_WIDTH),
        .CS_WIDTH   (CS_WIDTH)
    ) i_ac_cmd_encoder (
        .pll_afi_clk (pll_afi_clk),
        .rst         (rst),
        .afi_cmd     (afi_cmd),
        .afi_cs      (afi_cs),
        .afi_ba      (afi_ba),
        .afi_addr    (afi_addr),
        .ac_afi_word (ac_afi_word)
    );

    ac_pad #(
        .WORD_WIDTH   (WORD_WIDTH),
        .REGISTER_C2P (REGISTER_C2P)
    ) i_ac_pad (
        .pll_afi_clk (pll_afi_clk),
        .ac_afi_word (ac_afi_word),
        .ac_mem_word (ac_mem_word)
    );

    // Split the pin word back into named memory pins
    assign mem_cs_n  = ac_mem_word[WORD_WIDTH-1 -: CS_WIDTH];
    assign mem_ras_n = ac_mem_word[RAS_N_BIT];
    assign mem_cas_n = ac_mem_word[CAS_N_BIT];
    assign mem_we_n  = ac_mem_word[WE_N_BIT];
    assign mem_cke   = ac_mem_word[CKE_BIT];
    assign mem_ba    = ac_mem_word[ADDR_WIDTH +: BANK_WIDTH];
    assign mem_a     = ac_mem_word[ADDR_WIDTH-1:0];

endmodule

// ==== ac_pad.sv ====
// Address/command output pad
`timescale 1ns/1ps

module ac_pad #(
    parameter int WORD_WIDTH   = 4 + ac_pkg::CS_WIDTH_DEF + ac_pkg::BANK_WIDTH_DEF
                                   + ac_pkg::ADDR_WIDTH_DEF,
    parameter bit REGISTER_C2P = 1'b1
) (
    input  logic                  pll_afi_clk,
    input  logic [WORD_WIDTH-1:0] ac_afi_word,
    output logic [WORD_WIDTH-1:0] ac_mem_word
);

    // ******************************
    // Core to periphery boundary
    // ******************************

    // Word as seen on the periphery side of the boundary
    logic [WORD_WIDTH-1:0] c2p_word;

    // SDR output register in the I/O periphery
    logic [WORD_WIDTH-1:0] out_word_q;

    generate
        if (REGISTER_C2P) begin : g_c2p_reg
            // Extra flop stage eases timing across the core/periphery boundary
            always_ff @(posedge pll_afi_clk) begin
                c2p_word <= ac_afi_word;
            end
        end else begin : g_c2p_pass
            // Boundary crossed combinationally, one cycle less latency
            assign c2p_word = ac_afi_word;
        end
    endgenerate

    // ******************************
    // SDR output register
    // ******************************

    // In SDR mode the double-rate output cell reduces to one flop per pin,
    // clocked by the AFI clock and launching on its rising edge
    always_ff @(posedge pll_afi_clk) begin
        out_word_q <= c2p_word;
    end

    // Memory pins come straight from the output register
    assign ac_mem_word = out_word_q;

endmodule

// ==== ac_cmd_encoder.sv ====
// AFI command encoder
`timescale 1ns/1ps

module ac_cmd_encoder #(
    parameter int ADDR_WIDTH = ac_pkg::ADDR_WIDTH_DEF,
    parameter int BANK_WIDTH = ac_pkg::BANK_WIDTH_DEF,
    parameter int CS_WIDTH   = ac_pkg::CS_WIDTH_DEF
) (
    input  logic                                      pll_afi_clk,
    input  logic                                      rst,
    input  ac_pkg::ac_cmd_t                           afi_cmd,
    input  logic [$clog2(CS_WIDTH)-1:0]               afi_cs,
    input  logic [BANK_WIDTH-1:0]                     afi_ba,
    input  logic [ADDR_WIDTH-1:0]                     afi_addr,
    output logic [4+CS_WIDTH+BANK_WIDTH+ADDR_WIDTH-1:0] ac_afi_word
);

    import ac_pkg::*;

    // ******************************
    // Next-state signals
    // ******************************

    // Selected chip select driven low, all others high
    logic [CS_WIDTH-1:0]   cs_sel_n;

    logic [CS_WIDTH-1:0]   cs_n_d;
    logic                  ras_n_d;
    logic                  cas_n_d;
    logic                  we_n_d;
    logic                  cke_d;
    logic [BANK_WIDTH-1:0] ba_d;
    logic [ADDR_WIDTH-1:0] addr_d;

    // Registered fields of the AFI word
    logic [CS_WIDTH-1:0]   cs_n_q;
    logic                  ras_n_q;
    logic                  cas_n_q;
    logic                  we_n_q;
    logic                  cke_q;
    logic [BANK_WIDTH-1:0] ba_q;
    logic [ADDR_WIDTH-1:0] addr_q;

    // ******************************
    // Chip select decode
    // ******************************

    // One-hot-low decode of the chip select index
    always_comb begin
        for (int i = 0; i < CS_WIDTH; i++) begin
            cs_sel_n[i] = (afi_cs != i);
        end
    end

    // ******************************
    // Opcode decode
    // ******************************

    always_comb begin
        // Strobes idle high, the addressed rank is selected and cke holds
        cs_n_d  = cs_sel_n;
        ras_n_d = 1'b1;
        cas_n_d = 1'b1;
        we_n_d  = 1'b1;
        cke_d   = cke_q;
        ba_d    = afi_ba;
        addr_d  = afi_addr;

        unique case (afi_cmd)
            CMD_NOP: begin
                // Deselect every rank and park the address bus at zero
                cs_n_d = '1;
                ba_d   = '0;
                addr_d = '0;
            end
            CMD_ACT: begin
                ras_n_d = 1'b0;
            end
            CMD_RD: begin
                cas_n_d = 1'b0;
            end
            CMD_WR: begin
                cas_n_d = 1'b0;
                we_n_d  = 1'b0;
            end
            CMD_PRE: begin
                ras_n_d = 1'b0;
                we_n_d  = 1'b0;
            end
            CMD_REF: begin
                ras_n_d = 1'b0;
                cas_n_d = 1'b0;
            end
            CMD_MRS: begin
                ras_n_d = 1'b0;
                cas_n_d = 1'b0;
                we_n_d  = 1'b0;
            end
            CMD_PD: begin
                // Power-down entry or exit happens with all ranks deselected
                cs_n_d = '1;
                ba_d   = '0;
                addr_d = '0;
                cke_d  = ~cke_q;
            end
        endcase
    end

    // ******************************
    // AFI word register
    // ******************************

    // Reset forces a NOP with cke low, which is also the power-up state
    always_ff @(posedge pll_afi_clk) begin
        if (rst) begin
            cs_n_q  <= '1;
            ras_n_q <= 1'b1;
            cas_n_q <= 1'b1;
            we_n_q  <= 1'b1;
            cke_q   <= 1'b0;
            ba_q    <= '0;
            addr_q  <= '0;
        end else begin
            cs_n_q  <= cs_n_d;
            ras_n_q <= ras_n_d;
            cas_n_q <= cas_n_d;
            we_n_q  <= we_n_d;
            cke_q   <= cke_d;
            ba_q    <= ba_d;
            addr_q  <= addr_d;
        end
    end

    // Field order follows the layout stated in the package
    assign ac_afi_word = {cs_n_q, ras_n_q, cas_n_q, we_n_q, cke_q, ba_q, addr_q};

endmodule

// ==== ac_pkg.sv ====
// Address/command shared definitions

package ac_pkg;

    // ******************************
    // Default field widths
    // ******************************

    // Row/column address bits on the memory pins
    parameter int ADDR_WIDTH_DEF = 14;

    // Bank address bits
    parameter int BANK_WIDTH_DEF = 3;

    // Number of chip selects, one rank per select
    parameter int CS_WIDTH_DEF = 2;

    // ******************************
    // AFI command opcodes
    // ******************************

    // Opcodes as issued by the controller at the AFI boundary
    // CMD_PD flips the power-down state, so cke goes low if it was high
    // and high if it was low
    typedef enum logic [2:0] {
        CMD_NOP = 3'd0,
        CMD_ACT = 3'd1,
        CMD_RD  = 3'd2,
        CMD_WR  = 3'd3,
        CMD_PRE = 3'd4,
        CMD_REF = 3'd5,
        CMD_MRS = 3'd6,
        CMD_PD  = 3'd7
    } ac_cmd_t;

    // Packed AFI word layout, most significant field first
    //   cs_n [CS_WIDTH], ras_n, cas_n, we_n, cke, ba [BANK_WIDTH], addr [ADDR_WIDTH]
    // The word is 4 + CS_WIDTH + BANK_WIDTH + ADDR_WIDTH bits wide and every
    // module derives that width from its own width parameters

endpackage
